//--- run.sh
#!/bin/sh
# Build and run the MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module mac_tb -f src.f -o mac_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mac_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi

echo "Simulation passed"
exit 0

//--- src.f
verilog/mac_pkg.sv
verilog/mac_op_if.sv
verilog/booth_pp_gen.sv
verilog/csa_tree.sv
verilog/cla_adder.sv
verilog/mac_datapath.sv
verilog/mac_regs.sv
verilog/mac_top.sv
verification/mac_checker.sv
verification/mac_tb.sv

//--- verification/mac_checker.sv
`timescale 1ns/1ps

module mac_checker (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  mac_pkg::wb_adr_t  wb_adr,
	input  mac_pkg::wb_data_t wb_dat_w,
	input  mac_pkg::wb_data_t wb_dat_r,
	input  logic              wb_ack,
	input  logic              entry_done,
	input  int                entry_idx,
	input  logic              exp_valid,
	input  mac_pkg::result_t  exp_result,
	output int                read_count,
	output int                error_count
);
	import mac_pkg::*;

	// Mirror of the register block
	operand_t   m_a;
	operand_t   m_b;
	acc_t       m_acc;
	logic [1:0] m_op;
	result_t    m_result;
	logic       m_busy;

	// Operation in flight and the monitor edges until it lands
	result_t    m_next;
	int         busy_left;

	// Request seen on the bus and completed by the next ack
	logic       pend;
	logic       pend_we;
	wb_adr_t    pend_adr;
	wb_data_t   pend_wdat;
	result_t    last_result;
	int         entry_errors;

	function automatic string reg_name(wb_adr_t adr);
		case (adr)
			REG_OPERAND: return "REG_OPERAND";
			REG_ACC:     return "REG_ACC";
			REG_CONTROL: return "REG_CONTROL";
			default:     return "REG_RESULT";
		endcase
	endfunction

	// Signed arithmetic on plain integers wrapped to the result width
	function automatic result_t model_result(logic [1:0] op, operand_t a, operand_t b,
			acc_t acc);
		int sa;
		int sb;
		int sacc;
		int r;
		sa   = int'($signed(a));
		sb   = int'($signed(b));
		sacc = int'($signed(acc));
		case (op)
			2'd0:    r = sa * sb + sacc;
			2'd1:    r = sa * sb - sacc;
			2'd2:    r = sa + sb;
			default: r = sa - sb;
		endcase
		return result_t'(r);
	endfunction

	task automatic report_err(string name, wb_data_t exp, wb_data_t got);
		error_count++;
		entry_errors++;
		$display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
	endtask

	// Result lands three edges after the go is acknowledged
	task automatic advance_busy();
		if (busy_left > 0) begin
			busy_left--;
			if (busy_left == 0) begin
				m_result = m_next;
				if (!m_op[1])
					m_acc = m_next[11:0];
				m_busy = 1'b0;
			end
		end
	endtask

	task automatic apply_write(wb_adr_t adr, wb_data_t wdat);
		case (adr)
			REG_OPERAND: begin
				m_a = wdat[5:0];
				m_b = wdat[13:8];
			end
			REG_ACC:
				m_acc = wdat[11:0];
			REG_CONTROL:
				// Ignored entirely while an operation is in flight
				if (!m_busy) begin
					m_op = wdat[1:0];
					if (wdat[CTRL_GO_BIT]) begin
						m_next    = model_result(m_op, m_a, m_b, m_acc);
						busy_left = 4;
						m_busy    = 1'b1;
					end
				end
			default: ;
		endcase
	endtask

	task automatic check_read(wb_adr_t adr, wb_data_t got);
		wb_data_t exp;
		case (adr)
			REG_OPERAND: exp = {2'b00, m_b, 2'b00, m_a};
			REG_ACC:     exp = {{4{m_acc[11]}}, m_acc};
			REG_CONTROL: exp = {7'b0, m_busy, 6'b0, m_op};
			default: begin
				exp         = {{3{m_result[12]}}, m_result};
				last_result = got[12:0];
			end
		endcase
		read_count++;
		if (got !== exp)
			report_err(reg_name(adr), exp, got);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus monitor
	//////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		if (rst) begin
			m_a          = '0;
			m_b          = '0;
			m_acc        = '0;
			m_op         = '0;
			m_result     = '0;
			m_busy       = 1'b0;
			m_next       = '0;
			busy_left    = 0;
			pend         = 1'b0;
			last_result  = '0;
			entry_errors = 0;
			read_count   = 0;
			error_count  = 0;
		end else begin
			advance_busy();
			if (pend && wb_ack) begin
				pend = 1'b0;
				if (pend_we)
					apply_write(pend_adr, pend_wdat);
				else
					check_read(pend_adr, wb_dat_r);
			end else if (wb_ack) begin
				error_count++;
				entry_errors++;
				$display("Ack at %0t without a pending request", $time);
			end
			if (wb_cyc && wb_stb && !wb_ack) begin
				pend      = 1'b1;
				pend_we   = wb_we;
				pend_adr  = wb_adr;
				pend_wdat = wb_dat_w;
			end
			if (entry_done) begin
				if (exp_valid && last_result !== exp_result)
					report_err("REG_RESULT (table)", 16'(exp_result), 16'(last_result));
				if (entry_idx < 0)
					$display("Reset check done, %0d errors", entry_errors);
				else
					$display("Entry %0d done, %0d errors", entry_idx, entry_errors);
				entry_errors = 0;
			end
		end
	end

endmodule

//--- verification/mac_tb.sv
`timescale 1ns/1ps

module mac_tb;
	import mac_pkg::*;

	localparam int NUM_ENTRIES  = 19;
	localparam int RESET_CYCLES = 4;
	localparam int CYCLE_LIMIT  = 2 * NUM_ENTRIES * 16 + RESET_CYCLES;

	typedef struct packed {
		logic [1:0] op;
		operand_t   a;
		operand_t   b;
		logic       load_acc;
		acc_t       acc;
		logic       busy_go;
		logic       rnd;
		result_t    exp_res;
	} stim_t;

	// op, a, b, load acc, acc, go while busy, random, expected result
	localparam stim_t STIM [NUM_ENTRIES] = '{
		'{op_mac_add, 6'h20, 6'h20, 1'b1, 12'h000, 1'b0, 1'b0, 13'h0400},
		'{op_mac_add, 6'h20, 6'h1f, 1'b1, 12'h7ff, 1'b0, 1'b0, 13'h041f},
		'{op_mac_sub, 6'h20, 6'h20, 1'b1, 12'h800, 1'b0, 1'b0, 13'h0c00},
		'{op_mac_sub, 6'h20, 6'h1f, 1'b1, 12'h7ff, 1'b0, 1'b0, 13'h1421},
		// Chained on the accumulator left by the row above
		'{op_mac_add, 6'h03, 6'h05, 1'b0, 12'h000, 1'b0, 1'b0, 13'h0430},
		'{op_mac_add, 6'h3f, 6'h07, 1'b0, 12'h000, 1'b0, 1'b0, 13'h0429},
		'{op_add,     6'h1f, 6'h1f, 1'b0, 12'h000, 1'b0, 1'b0, 13'h003e},
		'{op_sub,     6'h20, 6'h1f, 1'b0, 12'h000, 1'b0, 1'b0, 13'h1fc1},
		'{op_add,     6'h20, 6'h20, 1'b0, 12'h000, 1'b0, 1'b0, 13'h1fc0},
		'{op_mac_sub, 6'h05, 6'h3a, 1'b1, 12'h064, 1'b1, 1'b0, 13'h1f7e},
		'{op_mac_add, 6'h02, 6'h03, 1'b0, 12'h000, 1'b1, 1'b0, 13'h1f84},
		'{op_mac_add, 6'h00, 6'h00, 1'b1, 12'h000, 1'b0, 1'b1, 13'h0000},
		'{op_mac_sub, 6'h00, 6'h00, 1'b0, 12'h000, 1'b0, 1'b1, 13'h0000},
		'{op_add,     6'h00, 6'h00, 1'b1, 12'h000, 1'b0, 1'b1, 13'h0000},
		'{op_sub,     6'h00, 6'h00, 1'b0, 12'h000, 1'b1, 1'b1, 13'h0000},
		'{op_mac_add, 6'h00, 6'h00, 1'b0, 12'h000, 1'b0, 1'b1, 13'h0000},
		'{op_mac_sub, 6'h00, 6'h00, 1'b1, 12'h000, 1'b0, 1'b1, 13'h0000},
		'{op_add,     6'h00, 6'h00, 1'b0, 12'h000, 1'b0, 1'b1, 13'h0000},
		'{op_sub,     6'h00, 6'h00, 1'b1, 12'h000, 1'b0, 1'b1, 13'h0000}
	};

	logic        clk;
	logic        rst;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	wb_adr_t     wb_adr;
	wb_data_t    wb_dat_w;
	wb_data_t    wb_dat_r;
	logic        wb_ack;
	logic        entry_done;
	int          entry_idx;
	logic        exp_valid;
	result_t     exp_result;
	int          read_count;
	int          error_count;
	logic [31:0] lfsr;
	int          cycles = 0;

	mac_top #(
		.CLA_GROUP_W (3)
	) i_mac_top (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	mac_checker i_mac_checker (
		.clk         (clk),
		.rst         (rst),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.entry_done  (entry_done),
		.entry_idx   (entry_idx),
		.exp_valid   (exp_valid),
		.exp_result  (exp_result),
		.read_count  (read_count),
		.error_count (error_count)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Random source and bus master
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [11:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[10:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// Called 1 ns after a rising edge, returns at the same phase
	task automatic bus_xfer(input logic we, input wb_adr_t adr, input wb_data_t wdat,
			output wb_data_t rdat);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		rdat   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input wb_adr_t adr, input wb_data_t wdat);
		wb_data_t unused;
		bus_xfer(1'b1, adr, wdat, unused);
	endtask

	task automatic bus_read(input wb_adr_t adr, output wb_data_t rdat);
		bus_xfer(1'b0, adr, '0, rdat);
	endtask

	task automatic signal_entry(input int idx, input logic chk, input result_t res);
		entry_idx  = idx;
		exp_valid  = chk;
		exp_result = res;
		entry_done = 1'b1;
		@(posedge clk);
		#1;
		entry_done = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////
	initial begin : stimulus
		stim_t       e;
		logic [11:0] bits;
		wb_data_t    rd;
		rst        = 1'b1;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		entry_done = 1'b0;
		entry_idx  = 0;
		exp_valid  = 1'b0;
		exp_result = '0;
		lfsr       = 32'h7c48;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// Every register reads zero out of reset
		bus_read(REG_OPERAND, rd);
		bus_read(REG_ACC, rd);
		bus_read(REG_CONTROL, rd);
		bus_read(REG_RESULT, rd);
		signal_entry(-1, 1'b0, '0);

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			e = STIM[i];
			if (e.rnd) begin
				draw_bits(OPERAND_W, bits);
				e.a = bits[5:0];
				draw_bits(OPERAND_W, bits);
				e.b = bits[5:0];
				draw_bits(ACC_W, bits);
				e.acc = bits;
			end
			bus_write(REG_OPERAND, {2'b00, e.b, 2'b00, e.a});
			bus_read(REG_OPERAND, rd);
			if (e.load_acc) begin
				bus_write(REG_ACC, {4'b0000, e.acc});
				bus_read(REG_ACC, rd);
			end
			bus_write(REG_CONTROL, {11'd0, 1'b1, 2'b00, e.op});
			// Lands while the first operation is still in the pipeline
			if (e.busy_go)
				bus_write(REG_CONTROL, {11'd0, 1'b1, 2'b00, e.op});
			do begin
				bus_read(REG_CONTROL, rd);
			end while (rd[CTRL_BUSY_BIT]);
			bus_read(REG_RESULT, rd);
			bus_read(REG_ACC, rd);
			signal_entry(i, !e.rnd, e.exp_res);
		end

		$display("%0d entries, %0d reads checked, %0d errors",
			NUM_ENTRIES, read_count, error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- verilog/booth_pp_gen.sv
`timescale 1ns/1ps

module booth_pp_gen (
	input  mac_pkg::operand_t a,
	input  mac_pkg::operand_t b,
	output logic [11:0]       pp0,
	output logic [9:0]        pp1,
	output logic [7:0]        pp2,
	output logic [2:0]        neg
);
	import mac_pkg::*;

	localparam int DIGITS = OPERAND_W / 2;

	// b with the implicit zero below bit 0
	logic [OPERAND_W:0] b_ext;
	// a sign-extended by one bit, and 2a
	logic [OPERAND_W:0] a_one;
	logic [OPERAND_W:0] a_two;
	logic [DIGITS-1:0]  single;
	logic [DIGITS-1:0]  double;
	logic [OPERAND_W:0] row [DIGITS];

	assign b_ext = {b, 1'b0};
	assign a_one = {a[OPERAND_W-1], a};
	assign a_two = {a, 1'b0};

	for (genvar i = 0; i < DIGITS; i++) begin : g_digit
		// Triple is b[2i+1], b[2i], b[2i-1]
		assign single[i] = b_ext[2*i+1] ^ b_ext[2*i];
		assign double[i] = ~single[i] & (b_ext[2*i+2] ^ b_ext[2*i+1]);
		assign neg[i]    = b_ext[2*i+2];

		// One's complement on negate, the +1 goes into the tree
		assign row[i] = (({(OPERAND_W+1){single[i]}} & a_one)
			| ({(OPERAND_W+1){double[i]}} & a_two))
			^ {(OPERAND_W+1){neg[i]}};
	end

	// Sign-extend each row up to bit 11 of the product
	assign pp0 = {{5{row[0][OPERAND_W]}}, row[0]};
	assign pp1 = {{3{row[1][OPERAND_W]}}, row[1]};
	assign pp2 = {row[2][OPERAND_W], row[2]};

endmodule

//--- verilog/cla_adder.sv
`timescale 1ns/1ps

module cla_adder #(
	parameter int WIDTH       = mac_pkg::RESULT_W,
	parameter int CLA_GROUP_W = 3
) (
	input  logic [WIDTH-1:0] x,
	input  logic [WIDTH-1:0] y,
	output logic [WIDTH-1:0] sum
);

	localparam int NUM_GROUPS = (WIDTH + CLA_GROUP_W - 1) / CLA_GROUP_W;
	localparam int PAD_W      = NUM_GROUPS * CLA_GROUP_W;

	// Bits above WIDTH are zero, so they neither propagate nor generate
	logic [PAD_W-1:0]      p;
	logic [PAD_W-1:0]      g;
	logic [PAD_W-1:0]      c;
	logic [NUM_GROUPS-1:0] grp_p;
	logic [NUM_GROUPS-1:0] grp_g;
	logic [NUM_GROUPS-1:0] grp_c;

	assign p = PAD_W'(x ^ y);
	assign g = PAD_W'(x & y);

	// Group propagate and generate
	always_comb begin : group_pg
		logic gp;
		logic gg;
		for (int k = 0; k < NUM_GROUPS; k++) begin
			gp = 1'b1;
			gg = 1'b0;
			for (int j = 0; j < CLA_GROUP_W; j++) begin
				gg = g[k*CLA_GROUP_W + j] | (p[k*CLA_GROUP_W + j] & gg);
				gp = gp & p[k*CLA_GROUP_W + j];
			end
			grp_p[k] = gp;
			grp_g[k] = gg;
		end
	end

	// Second level gives each group its carry-in, then carries inside groups
	always_comb begin : carries
		logic bc;
		grp_c[0] = 1'b0;
		for (int k = 1; k < NUM_GROUPS; k++)
			grp_c[k] = grp_g[k-1] | (grp_p[k-1] & grp_c[k-1]);
		for (int k = 0; k < NUM_GROUPS; k++) begin
			bc = grp_c[k];
			for (int j = 0; j < CLA_GROUP_W; j++) begin
				c[k*CLA_GROUP_W + j] = bc;
				bc = g[k*CLA_GROUP_W + j] | (p[k*CLA_GROUP_W + j] & bc);
			end
		end
	end

	assign sum = p[WIDTH-1:0] ^ c[WIDTH-1:0];

endmodule

//--- verilog/csa_tree.sv
`timescale 1ns/1ps

module csa_tree (
	input  logic [11:0]      pp0,
	input  logic [9:0]       pp1,
	input  logic [7:0]       pp2,
	input  logic [2:0]       neg,
	input  mac_pkg::result_t addend,
	input  logic             cin,
	output mac_pkg::result_t sum,
	output mac_pkg::result_t carry
);
	import mac_pkg::*;

	// Rows aligned to the product weight, all 13 bits wide
	result_t row0;
	result_t row1;
	result_t row2;
	result_t neg_row;
	result_t s1;
	result_t c1;
	result_t s2;
	result_t c2;

	// Carry of a 3:2 compressor row
	function automatic result_t maj3(result_t x, result_t y, result_t z);
		return (x & y) | (x & z) | (y & z);
	endfunction

	assign row0    = {pp0[11], pp0};
	assign row1    = {pp1[9], pp1, 2'b00};
	assign row2    = {pp2[7], pp2, 4'b0000};
	// Booth negate corrections sit at the LSB of their digit
	assign neg_row = {8'b0, neg[2], 1'b0, neg[1], 1'b0, neg[0]};

	//////////////////////////////////////////////////////////////////////
	// Level 1 and 2, product reduction
	//////////////////////////////////////////////////////////////////////

	// Sparse in the low bits, so mostly half adders
	assign s1 = row1 ^ row2 ^ neg_row;
	assign c1 = maj3(row1, row2, neg_row) << 1;

	assign s2 = row0 ^ s1 ^ c1;
	assign c2 = maj3(row0, s1, c1) << 1;

	//////////////////////////////////////////////////////////////////////
	// Level 3, accumulator row
	//////////////////////////////////////////////////////////////////////

	// Carry LSB is free after the shift, cin completes the two's complement
	assign sum   = s2 ^ c2 ^ addend;
	assign carry = (maj3(s2, c2, addend) << 1) | RESULT_W'(cin);

endmodule

//--- verilog/mac_datapath.sv
`timescale 1ns/1ps

module mac_datapath #(
	parameter int CLA_GROUP_W = 3
) (
	input  logic     clk,
	input  logic     rst,
	mac_op_if.engine op_bus
);
	import mac_pkg::*;

	logic [11:0] pp0;
	logic [9:0]  pp1;
	logic [7:0]  pp2;
	logic [2:0]  neg;
	logic        sub;
	result_t     addend;
	result_t     mac_sum;
	result_t     mac_carry;
	result_t     as_x;
	result_t     as_y;
	result_t     as_cin;
	result_t     as_sum;
	result_t     as_carry;

	logic        s1_valid;
	logic        s1_as_path;
	result_t     s1_mac_sum;
	result_t     s1_mac_carry;
	result_t     s1_as_sum;
	result_t     s1_as_carry;
	result_t     add_x;
	result_t     add_y;
	result_t     add_sum;
	logic        s2_valid;
	result_t     s2_result;

	assign sub = op_bus.op[0];

	//////////////////////////////////////////////////////////////////////
	// Stage 0, multiply tree and add/subtract compression
	//////////////////////////////////////////////////////////////////////
	booth_pp_gen i_booth_pp_gen (
		.a   (op_bus.a),
		.b   (op_bus.b),
		.pp0 (pp0),
		.pp1 (pp1),
		.pp2 (pp2),
		.neg (neg)
	);

	// acc is inverted for a*b - acc
	assign addend = {op_bus.acc[ACC_W-1], op_bus.acc} ^ {RESULT_W{sub}};

	csa_tree i_csa_tree (
		.pp0    (pp0),
		.pp1    (pp1),
		.pp2    (pp2),
		.neg    (neg),
		.addend (addend),
		.cin    (sub),
		.sum    (mac_sum),
		.carry  (mac_carry)
	);

	assign as_x     = {{(RESULT_W-OPERAND_W){op_bus.a[OPERAND_W-1]}}, op_bus.a};
	assign as_y     = {{(RESULT_W-OPERAND_W){op_bus.b[OPERAND_W-1]}}, op_bus.b}
		^ {RESULT_W{sub}};
	assign as_cin   = RESULT_W'(sub);
	assign as_sum   = as_x ^ as_y ^ as_cin;
	assign as_carry = ((as_x & as_y) | ((as_x ^ as_y) & as_cin)) << 1;

	// Stage 1 register
	always_ff @(posedge clk) begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= op_bus.valid;
	end

	always_ff @(posedge clk) begin
		if (op_bus.valid) begin
			s1_as_path   <= op_bus.op[1];
			s1_mac_sum   <= mac_sum;
			s1_mac_carry <= mac_carry;
			s1_as_sum    <= as_sum;
			s1_as_carry  <= as_carry;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 1, select and final add
	//////////////////////////////////////////////////////////////////////
	assign add_x = s1_as_path ? s1_as_sum : s1_mac_sum;
	assign add_y = s1_as_path ? s1_as_carry : s1_mac_carry;

	cla_adder #(
		.WIDTH       (RESULT_W),
		.CLA_GROUP_W (CLA_GROUP_W)
	) i_cla_adder (
		.x   (add_x),
		.y   (add_y),
		.sum (add_sum)
	);

	always_ff @(posedge clk) begin
		if (rst)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		if (s1_valid)
			s2_result <= add_sum;
	end

	assign op_bus.result_valid = s2_valid;
	assign op_bus.result       = s2_result;

endmodule

//--- verilog/mac_op_if.sv
`timescale 1ns/1ps

interface mac_op_if;
	import mac_pkg::*;

	// Request, valid is a single-cycle pulse
	logic     valid;
	mac_op_e  op;
	operand_t a;
	operand_t b;
	acc_t     acc;

	// Response from the datapath
	logic     result_valid;
	result_t  result;

	modport issuer (
		output valid, op, a, b, acc,
		input  result_valid, result
	);

	modport engine (
		input  valid, op, a, b, acc,
		output result_valid, result
	);

endinterface

//--- verilog/mac_pkg.sv
package mac_pkg;

	// Datapath widths
	localparam int OPERAND_W = 6;
	localparam int ACC_W     = 12;
	localparam int RESULT_W  = 13;

	// Wishbone widths
	localparam int WB_DATA_W = 16;
	localparam int WB_ADR_W  = 2;

	typedef logic [OPERAND_W-1:0] operand_t;
	typedef logic [ACC_W-1:0]     acc_t;
	typedef logic [RESULT_W-1:0]  result_t;
	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [WB_ADR_W-1:0]  wb_adr_t;

	// Bit 0 selects subtract, bit 1 selects the plain add/subtract path
	typedef enum logic [1:0] {
		op_mac_add = 2'd0,
		op_mac_sub = 2'd1,
		op_add     = 2'd2,
		op_sub     = 2'd3
	} mac_op_e;

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////
	localparam wb_adr_t REG_OPERAND = 2'd0;
	localparam wb_adr_t REG_ACC     = 2'd1;
	localparam wb_adr_t REG_CONTROL = 2'd2;
	localparam wb_adr_t REG_RESULT  = 2'd3;

	// Field positions
	localparam int OPERAND_B_LSB = 8;
	localparam int CTRL_GO_BIT   = 4;
	localparam int CTRL_BUSY_BIT = 8;

	// Register block sequencer
	typedef enum logic {
		seq_idle,
		seq_busy
	} seq_state_e;

endpackage

//--- verilog/mac_regs.sv
`timescale 1ns/1ps

module mac_regs (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  mac_pkg::wb_adr_t  wb_adr,
	input  mac_pkg::wb_data_t wb_dat_w,
	output mac_pkg::wb_data_t wb_dat_r,
	output logic              wb_ack,
	mac_op_if.issuer          op_bus
);
	import mac_pkg::*;

	operand_t   a_q;
	operand_t   b_q;
	acc_t       acc_q;
	mac_op_e    op_q;
	result_t    result_q;
	seq_state_e state;
	logic       issue;
	logic       busy;
	logic       req;
	logic       wr;
	logic       ctrl_wr;
	logic       go;
	wb_data_t   rd_data;

	// New access only while ack is low
	assign req     = wb_cyc & wb_stb & ~wb_ack;
	assign wr      = req & wb_we;
	assign busy    = (state == seq_busy);
	assign ctrl_wr = wr && (wb_adr == REG_CONTROL) && !busy;
	assign go      = ctrl_wr && wb_dat_w[CTRL_GO_BIT];

	//////////////////////////////////////////////////////////////////////
	// Wishbone slave
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack   <= 1'b0;
			wb_dat_r <= '0;
		end else begin
			wb_ack <= req;
			if (req)
				wb_dat_r <= rd_data;
		end
	end

	always_comb begin
		rd_data = '0;
		case (wb_adr)
			REG_OPERAND: begin
				rd_data[OPERAND_W-1:0]                = a_q;
				rd_data[OPERAND_B_LSB +: OPERAND_W]   = b_q;
			end
			REG_ACC:
				rd_data = {{(WB_DATA_W-ACC_W){acc_q[ACC_W-1]}}, acc_q};
			REG_CONTROL: begin
				rd_data[1:0]          = op_q;
				rd_data[CTRL_BUSY_BIT] = busy;
			end
			REG_RESULT:
				rd_data = {{(WB_DATA_W-RESULT_W){result_q[RESULT_W-1]}}, result_q};
		endcase
	end

	// Register file, write-back from the datapath wins over a bus write
	always_ff @(posedge clk) begin
		if (rst) begin
			a_q      <= '0;
			b_q      <= '0;
			acc_q    <= '0;
			op_q     <= op_mac_add;
			result_q <= '0;
		end else begin
			if (wr && wb_adr == REG_OPERAND) begin
				a_q <= wb_dat_w[OPERAND_W-1:0];
				b_q <= wb_dat_w[OPERAND_B_LSB +: OPERAND_W];
			end
			if (wr && wb_adr == REG_ACC)
				acc_q <= wb_dat_w[ACC_W-1:0];
			if (ctrl_wr)
				op_q <= mac_op_e'(wb_dat_w[1:0]);
			if (op_bus.result_valid) begin
				result_q <= op_bus.result;
				// Only the MAC ops accumulate
				if (!op_q[1])
					acc_q <= op_bus.result[ACC_W-1:0];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= seq_idle;
			issue <= 1'b0;
		end else begin
			issue <= 1'b0;
			case (state)
				seq_idle:
					if (go) begin
						state <= seq_busy;
						issue <= 1'b1;
					end
				seq_busy:
					if (op_bus.result_valid)
						state <= seq_idle;
				default:
					state <= seq_idle;
			endcase
		end
	end

	assign op_bus.valid = issue;
	assign op_bus.op    = op_q;
	assign op_bus.a     = a_q;
	assign op_bus.b     = b_q;
	assign op_bus.acc   = acc_q;

endmodule

//--- verilog/mac_top.sv
`timescale 1ns/1ps

module mac_top #(
	parameter int CLA_GROUP_W = 3
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  mac_pkg::wb_adr_t  wb_adr,
	input  mac_pkg::wb_data_t wb_dat_w,
	output mac_pkg::wb_data_t wb_dat_r,
	output logic              wb_ack
);

	// Operation handoff between the register block and the datapath
	mac_op_if op_bus ();

	// Bus slave, register file and sequencer
	mac_regs i_mac_regs (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.op_bus   (op_bus)
	);

	// Two-stage MAC pipeline
	mac_datapath #(
		.CLA_GROUP_W (CLA_GROUP_W)
	) i_mac_datapath (
		.clk    (clk),
		.rst    (rst),
		.op_bus (op_bus)
	);

endmodule
